// File: wb_settings.svh
//##########################################################
// Shared size macros for the writeback stage
// Lane, thread and register counts, PC register index
//##########################################################

`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Lanes per vector, also words per cache line
`define VECTOR_LANES 4

`define NUM_THREADS 2

// Registers per file, scalar and vector alike
`define NUM_REGS 32

`define REG_PC 31

`endif

// File: wb_pkg.sv
//##########################################################
// Writeback package
// Word, vector and index types, memory-op and pipeline enums
// Decoded instruction struct and the cache lane union
//##########################################################

`include "wb_settings.svh"

package wb_pkg;

	typedef logic [31:0] scalar_t;

	// Always read in whole lanes
	typedef scalar_t [`VECTOR_LANES-1:0] vector_t;

	typedef logic [$clog2(`NUM_THREADS)-1:0] thread_idx_t;
	typedef logic [4:0] register_idx_t;

	// Lane index of a gather, one lane per subcycle
	typedef logic [$clog2(`VECTOR_LANES)-1:0] subcycle_t;

	typedef enum logic [3:0]
	{
		MEM_B,
		MEM_BX,
		MEM_S,
		MEM_SX,
		MEM_L,
		MEM_SYNC,
		MEM_CONTROL_REG,
		MEM_BLOCK,
		MEM_GATHER
	} mem_op_t;

	typedef enum logic [1:0]
	{
		PIPE_SCYCLE_ARITH,
		PIPE_MCYCLE_ARITH,
		PIPE_MEM
	} pipeline_sel_t;

	typedef struct packed
	{
		logic has_dest;
		register_idx_t dest_reg;
		logic dest_is_vector;
		logic is_compare;
		logic is_call;
		logic is_load;
		mem_op_t mem_op;
		subcycle_t last_subcycle;
	} decoded_instruction_t;

	// One big-endian cache lane, byte 0 sits in bits 31:24
	typedef union packed
	{
		logic [3:0][7:0] bytes;
		logic [1:0][15:0] halves;
	} cache_lane_u;

endpackage

// File: writeback_if.sv
//##########################################################
// Registered writeback bundle into the register file
//##########################################################

`include "wb_settings.svh"

interface writeback_if;

	logic en;
	wb_pkg::thread_idx_t thread_idx;
	logic is_vector;
	wb_pkg::vector_t value;
	logic [`VECTOR_LANES-1:0] mask;
	wb_pkg::register_idx_t reg_idx;
	logic is_last_subcycle;

	modport source(output en, thread_idx, is_vector, value, mask, reg_idx,
		is_last_subcycle);

	// The register file ignores subcycle boundaries
	modport sink(input en, thread_idx, is_vector, value, mask, reg_idx);

endinterface

// File: load_aligner.sv
//##########################################################
// Load aligner
// Lane select, scalar alignment with extension, line swap
//##########################################################

`include "wb_settings.svh"

module load_aligner(
	input wb_pkg::scalar_t dd_request_addr,
	input wb_pkg::vector_t dd_read_data,
	input wb_pkg::mem_op_t dd_mem_op,
	output wb_pkg::scalar_t aligned_value,
	output wb_pkg::vector_t swapped_line
);

	import wb_pkg::*;

	subcycle_t lane_offset;
	cache_lane_u lane;
	logic [7:0] byte_value;
	logic [15:0] half_value;

	// Line words are stored MSB first
	assign lane_offset = dd_request_addr[2 +: $bits(subcycle_t)];
	assign lane = dd_read_data[`VECTOR_LANES - 1 - lane_offset];

	// Lowest address is the most significant byte
	assign byte_value = lane.bytes[3 - dd_request_addr[1:0]];

	// Halfword comes out little-endian
	always_comb
	begin
		if (dd_request_addr[1])
			half_value = {lane.halves[0][7:0], lane.halves[0][15:8]};
		else
			half_value = {lane.halves[1][7:0], lane.halves[1][15:8]};
	end

	always_comb
	begin
		case (dd_mem_op)
			MEM_B:
				aligned_value = {24'b0, byte_value};
			MEM_BX:
				aligned_value = {{24{byte_value[7]}}, byte_value};
			MEM_S:
				aligned_value = {16'b0, half_value};
			MEM_SX:
				aligned_value = {{16{half_value[15]}}, half_value};
			// Whole word, also sync and gather lanes
			default:
				aligned_value = {<<8{lane.bytes}};
		endcase
	end

	// Block loads see every word byte-reversed
	for (genvar w = 0; w < `VECTOR_LANES; w++)
	begin : g_swap
		assign swapped_line[w] = {<<8{dd_read_data[w]}};
	end

endmodule

// File: rollback_arbiter.sv
//##########################################################
// Rollback arbiter
// Same-cycle choice of the one rollback request
//##########################################################

`include "wb_settings.svh"

module rollback_arbiter(
	input logic sx_valid,
	input wb_pkg::decoded_instruction_t sx_instruction,
	input wb_pkg::vector_t sx_result,
	input wb_pkg::thread_idx_t sx_thread_idx,
	input logic sx_rollback_en,
	input wb_pkg::scalar_t sx_rollback_pc,
	input wb_pkg::subcycle_t sx_subcycle,
	input logic dd_valid,
	input wb_pkg::decoded_instruction_t dd_instruction,
	input wb_pkg::thread_idx_t dd_thread_idx,
	input wb_pkg::subcycle_t dd_subcycle,
	input logic dd_rollback_en,
	input wb_pkg::scalar_t dd_rollback_pc,
	input wb_pkg::scalar_t aligned_value,
	output logic rollback_en,
	output wb_pkg::thread_idx_t rollback_thread_idx,
	output wb_pkg::scalar_t rollback_pc,
	output wb_pkg::pipeline_sel_t rollback_pipeline,
	output wb_pkg::subcycle_t rollback_subcycle
);

	import wb_pkg::*;

	logic sx_writes_pc;
	logic dd_loads_pc;

	assign sx_writes_pc = sx_valid && sx_instruction.has_dest
		&& !sx_instruction.dest_is_vector && sx_instruction.dest_reg == `REG_PC;

	// A cache miss rolls back on its own and wins over the PC load
	assign dd_loads_pc = dd_valid && dd_instruction.is_load && dd_instruction.has_dest
		&& !dd_instruction.dest_is_vector && dd_instruction.dest_reg == `REG_PC
		&& !dd_rollback_en;

	// Unregistered, so the next instruction is squashed before the edge
	always_comb
	begin
		rollback_en = 1'b0;
		rollback_thread_idx = '0;
		rollback_pc = '0;
		rollback_pipeline = PIPE_SCYCLE_ARITH;
		rollback_subcycle = '0;

		if (sx_writes_pc)
		begin
			rollback_en = 1'b1;
			rollback_thread_idx = sx_thread_idx;
			rollback_pc = sx_result[0];
		end
		else if (dd_loads_pc)
		begin
			rollback_en = 1'b1;
			rollback_thread_idx = dd_thread_idx;
			rollback_pc = aligned_value;
			rollback_pipeline = PIPE_MEM;
		end
		else if (sx_valid)
		begin
			rollback_en = sx_rollback_en;
			rollback_thread_idx = sx_thread_idx;
			rollback_pc = sx_rollback_pc;
			rollback_subcycle = sx_subcycle;
		end
		else if (dd_valid)
		begin
			rollback_en = dd_rollback_en;
			rollback_thread_idx = dd_thread_idx;
			rollback_pc = dd_rollback_pc;
			rollback_pipeline = PIPE_MEM;
			rollback_subcycle = dd_subcycle;
		end
	end

endmodule

// File: writeback_stage.sv
//##########################################################
// Writeback stage
// Picks the valid result and registers value, mask, enable
//##########################################################

`include "wb_settings.svh"

module writeback_stage(
	input logic clk,
	input logic reset,
	input logic mx_valid,
	input wb_pkg::decoded_instruction_t mx_instruction,
	input wb_pkg::vector_t mx_result,
	input logic [`VECTOR_LANES-1:0] mx_mask,
	input wb_pkg::thread_idx_t mx_thread_idx,
	input wb_pkg::subcycle_t mx_subcycle,
	input logic sx_valid,
	input wb_pkg::decoded_instruction_t sx_instruction,
	input wb_pkg::vector_t sx_result,
	input logic [`VECTOR_LANES-1:0] sx_mask,
	input wb_pkg::thread_idx_t sx_thread_idx,
	input wb_pkg::subcycle_t sx_subcycle,
	input logic dd_valid,
	input wb_pkg::decoded_instruction_t dd_instruction,
	input logic [`VECTOR_LANES-1:0] dd_mask,
	input wb_pkg::thread_idx_t dd_thread_idx,
	input wb_pkg::subcycle_t dd_subcycle,
	input logic dd_sync_store_success,
	input wb_pkg::scalar_t cr_read_value,
	input wb_pkg::scalar_t aligned_value,
	input wb_pkg::vector_t swapped_line,
	input logic rollback_en,
	writeback_if.source wb
);

	import wb_pkg::*;

	localparam logic [`VECTOR_LANES-1:0] FULL_MASK = '1;

	decoded_instruction_t instr;
	thread_idx_t sel_thread;
	subcycle_t sel_subcycle;
	vector_t next_value;
	logic [`VECTOR_LANES-1:0] next_mask;
	logic next_en;

	// Bit 0 of every lane packed into lane 0
	function automatic vector_t compare_mask(vector_t result);
		logic [`VECTOR_LANES-1:0] bits;
		vector_t packed_mask;
		for (int i = 0; i < `VECTOR_LANES; i++)
			bits[i] = result[i][0];
		packed_mask = '0;
		packed_mask[0] = scalar_t'(bits);
		return packed_mask;
	endfunction

	always_comb
	begin
		instr = '0;
		sel_thread = '0;
		sel_subcycle = '0;
		next_value = '0;
		next_mask = '0;

		// Producers keep the valids one-hot
		if (mx_valid)
		begin
			instr = mx_instruction;
			sel_thread = mx_thread_idx;
			sel_subcycle = mx_subcycle;
			next_value = mx_instruction.is_compare ? compare_mask(mx_result) : mx_result;
			next_mask = mx_mask;
		end
		else if (sx_valid)
		begin
			instr = sx_instruction;
			sel_thread = sx_thread_idx;
			sel_subcycle = sx_subcycle;
			next_value = sx_instruction.is_compare ? compare_mask(sx_result) : sx_result;
			next_mask = sx_mask;
		end
		else if (dd_valid)
		begin
			instr = dd_instruction;
			sel_thread = dd_thread_idx;
			sel_subcycle = dd_subcycle;
			if (dd_instruction.is_load)
			begin
				case (dd_instruction.mem_op)
					MEM_B, MEM_BX, MEM_S, MEM_SX, MEM_L, MEM_SYNC:
					begin
						next_value = {`VECTOR_LANES{aligned_value}};
						next_mask = FULL_MASK;
					end
					MEM_CONTROL_REG:
					begin
						next_value = {`VECTOR_LANES{cr_read_value}};
						next_mask = FULL_MASK;
					end
					MEM_BLOCK:
					begin
						next_value = swapped_line;
						next_mask = dd_mask;
					end
					// Subcycle names the lane, lane 0 is the top mask bit
					MEM_GATHER:
					begin
						next_value = {`VECTOR_LANES{aligned_value}};
						next_mask = dd_mask & (FULL_MASK >> (`VECTOR_LANES - 1)
							<< (`VECTOR_LANES - 1 - dd_subcycle));
					end
					default:
						next_mask = '0;
				endcase
			end
			else if (dd_instruction.mem_op == MEM_SYNC)
			begin
				// Sync store reports whether it succeeded
				next_value[0] = scalar_t'(dd_sync_store_success);
				next_mask = FULL_MASK;
			end
		end
	end

	// A call keeps its link register write despite the rollback
	assign next_en = (mx_valid || sx_valid || dd_valid) && instr.has_dest
		&& (instr.is_call || !rollback_en);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			wb.en <= 1'b0;
		else
			wb.en <= next_en;
	end

	always_ff @(posedge clk)
	begin
		wb.thread_idx <= sel_thread;
		wb.is_vector <= instr.dest_is_vector;
		wb.value <= next_value;
		wb.mask <= next_mask;
		wb.reg_idx <= instr.dest_reg;
		wb.is_last_subcycle <= sel_subcycle == instr.last_subcycle;
	end

endmodule

// File: vector_register_file.sv
//##########################################################
// Per-thread scalar and vector register files
//##########################################################

`include "wb_settings.svh"

module vector_register_file(
	input logic clk,
	input logic reset,
	writeback_if.sink wb,
	input wb_pkg::thread_idx_t read_thread_idx,
	input wb_pkg::register_idx_t read_reg_idx,
	input logic read_is_vector,
	output wb_pkg::vector_t read_value
);

	import wb_pkg::*;

	scalar_t scalar_regs [`NUM_THREADS][`NUM_REGS];
	vector_t vector_regs [`NUM_THREADS][`NUM_REGS];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int t = 0; t < `NUM_THREADS; t++)
			begin
				for (int r = 0; r < `NUM_REGS; r++)
				begin
					scalar_regs[t][r] <= '0;
					vector_regs[t][r] <= '0;
				end
			end
		end
		else if (wb.en)
		begin
			if (wb.is_vector)
			begin
				// Masked lanes keep their old contents
				for (int lane = 0; lane < `VECTOR_LANES; lane++)
				begin
					if (wb.mask[lane])
						vector_regs[wb.thread_idx][wb.reg_idx][lane] <= wb.value[lane];
				end
			end
			else
				scalar_regs[wb.thread_idx][wb.reg_idx] <= wb.value[0];
		end
	end

	// Scalar reads come back in every lane
	assign read_value = read_is_vector ? vector_regs[read_thread_idx][read_reg_idx]
		: {`VECTOR_LANES{scalar_regs[read_thread_idx][read_reg_idx]}};

endmodule

// File: writeback_top.sv
//##########################################################
// Writeback top level
// Aligner, rollback arbiter, stage and register file
//##########################################################

`include "wb_settings.svh"

module writeback_top(
	input logic clk,
	input logic reset,
	input logic mx_valid,
	input wb_pkg::decoded_instruction_t mx_instruction,
	input wb_pkg::vector_t mx_result,
	input logic [`VECTOR_LANES-1:0] mx_mask,
	input wb_pkg::thread_idx_t mx_thread_idx,
	input wb_pkg::subcycle_t mx_subcycle,
	input logic sx_valid,
	input wb_pkg::decoded_instruction_t sx_instruction,
	input wb_pkg::vector_t sx_result,
	input logic [`VECTOR_LANES-1:0] sx_mask,
	input wb_pkg::thread_idx_t sx_thread_idx,
	input wb_pkg::subcycle_t sx_subcycle,
	input logic sx_rollback_en,
	input wb_pkg::scalar_t sx_rollback_pc,
	input logic dd_valid,
	input wb_pkg::decoded_instruction_t dd_instruction,
	input logic [`VECTOR_LANES-1:0] dd_mask,
	input wb_pkg::thread_idx_t dd_thread_idx,
	input wb_pkg::subcycle_t dd_subcycle,
	input wb_pkg::scalar_t dd_request_addr,
	input wb_pkg::vector_t dd_read_data,
	input logic dd_rollback_en,
	input wb_pkg::scalar_t dd_rollback_pc,
	input logic dd_sync_store_success,
	input wb_pkg::scalar_t cr_read_value,
	output logic wb_rollback_en,
	output wb_pkg::thread_idx_t wb_rollback_thread_idx,
	output wb_pkg::scalar_t wb_rollback_pc,
	output wb_pkg::pipeline_sel_t wb_rollback_pipeline,
	output wb_pkg::subcycle_t wb_rollback_subcycle,
	output logic wb_writeback_en,
	output wb_pkg::thread_idx_t wb_writeback_thread_idx,
	output logic wb_writeback_is_vector,
	output wb_pkg::vector_t wb_writeback_value,
	output logic [`VECTOR_LANES-1:0] wb_writeback_mask,
	output wb_pkg::register_idx_t wb_writeback_reg,
	output logic wb_writeback_is_last_subcycle,
	input wb_pkg::thread_idx_t read_thread_idx,
	input wb_pkg::register_idx_t read_reg_idx,
	input logic read_is_vector,
	output wb_pkg::vector_t read_value
);

	import wb_pkg::*;

	scalar_t aligned_value;
	vector_t swapped_line;

	writeback_if wb_bus();

	load_aligner i_load_aligner(
		.dd_request_addr(dd_request_addr),
		.dd_read_data(dd_read_data),
		.dd_mem_op(dd_instruction.mem_op),
		.aligned_value(aligned_value),
		.swapped_line(swapped_line)
	);

	rollback_arbiter i_rollback_arbiter(
		.sx_valid(sx_valid),
		.sx_instruction(sx_instruction),
		.sx_result(sx_result),
		.sx_thread_idx(sx_thread_idx),
		.sx_rollback_en(sx_rollback_en),
		.sx_rollback_pc(sx_rollback_pc),
		.sx_subcycle(sx_subcycle),
		.dd_valid(dd_valid),
		.dd_instruction(dd_instruction),
		.dd_thread_idx(dd_thread_idx),
		.dd_subcycle(dd_subcycle),
		.dd_rollback_en(dd_rollback_en),
		.dd_rollback_pc(dd_rollback_pc),
		.aligned_value(aligned_value),
		.rollback_en(wb_rollback_en),
		.rollback_thread_idx(wb_rollback_thread_idx),
		.rollback_pc(wb_rollback_pc),
		.rollback_pipeline(wb_rollback_pipeline),
		.rollback_subcycle(wb_rollback_subcycle)
	);

	writeback_stage i_writeback_stage(
		.clk(clk),
		.reset(reset),
		.mx_valid(mx_valid),
		.mx_instruction(mx_instruction),
		.mx_result(mx_result),
		.mx_mask(mx_mask),
		.mx_thread_idx(mx_thread_idx),
		.mx_subcycle(mx_subcycle),
		.sx_valid(sx_valid),
		.sx_instruction(sx_instruction),
		.sx_result(sx_result),
		.sx_mask(sx_mask),
		.sx_thread_idx(sx_thread_idx),
		.sx_subcycle(sx_subcycle),
		.dd_valid(dd_valid),
		.dd_instruction(dd_instruction),
		.dd_mask(dd_mask),
		.dd_thread_idx(dd_thread_idx),
		.dd_subcycle(dd_subcycle),
		.dd_sync_store_success(dd_sync_store_success),
		.cr_read_value(cr_read_value),
		.aligned_value(aligned_value),
		.swapped_line(swapped_line),
		.rollback_en(wb_rollback_en),
		.wb(wb_bus.source)
	);

	vector_register_file i_vector_register_file(
		.clk(clk),
		.reset(reset),
		.wb(wb_bus.sink),
		.read_thread_idx(read_thread_idx),
		.read_reg_idx(read_reg_idx),
		.read_is_vector(read_is_vector),
		.read_value(read_value)
	);

	assign wb_writeback_en = wb_bus.en;
	assign wb_writeback_thread_idx = wb_bus.thread_idx;
	assign wb_writeback_is_vector = wb_bus.is_vector;
	assign wb_writeback_value = wb_bus.value;
	assign wb_writeback_mask = wb_bus.mask;
	assign wb_writeback_reg = wb_bus.reg_idx;
	assign wb_writeback_is_last_subcycle = wb_bus.is_last_subcycle;

endmodule

// File: writeback_assertions.sv
//##########################################################
// Bound assertions on the writeback stage
// One-hot valids, load destination, quiet enable after reset
//##########################################################

module writeback_assertions(
	input logic clk,
	input logic reset,
	input logic mx_valid,
	input logic sx_valid,
	input logic dd_valid,
	input wb_pkg::decoded_instruction_t dd_instruction,
	input logic wb_en
);

	// At most one producer retires per cycle
	one_hot_valid: assert property (@(posedge clk) disable iff (reset)
		$onehot0({mx_valid, sx_valid, dd_valid}))
		else $error("more than one producer valid in a cycle");

	load_has_dest: assert property (@(posedge clk) disable iff (reset)
		dd_valid && dd_instruction.is_load |-> dd_instruction.has_dest)
		else $error("load retired without a destination register");

	// First edge out of reset must not write
	quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !wb_en)
		else $error("write enable high in the cycle after reset");

endmodule

bind writeback_stage writeback_assertions i_writeback_assertions(
	.clk(clk),
	.reset(reset),
	.mx_valid(mx_valid),
	.sx_valid(sx_valid),
	.dd_valid(dd_valid),
	.dd_instruction(dd_instruction),
	.wb_en(wb.en)
);

// File: writeback_tb.sv
//##########################################################
// Writeback testbench
// Stimulus table, LFSR read data, reference rules, checks
//##########################################################

`include "wb_settings.svh"

module writeback_tb;

	import wb_pkg::*;

	localparam int PERIOD = 40;
	localparam int SX = 0;
	localparam int MX = 1;
	localparam int DD = 2;

	typedef logic [`VECTOR_LANES-1:0] mask_t;

	typedef struct {
		int pipe;
		decoded_instruction_t instr;
		scalar_t addr;
		thread_idx_t thread;
		mask_t mask;
		subcycle_t sub;
		logic rb_req;
		scalar_t rb_pc;
		logic exp_rb;
		logic exp_wen;
		mask_t exp_mask;
	} row_t;

	logic clk, reset;
	logic mx_valid, sx_valid, dd_valid;
	decoded_instruction_t mx_instruction, sx_instruction, dd_instruction;
	vector_t mx_result, sx_result, dd_read_data;
	mask_t mx_mask, sx_mask, dd_mask;
	thread_idx_t mx_thread_idx, sx_thread_idx, dd_thread_idx;
	subcycle_t mx_subcycle, sx_subcycle, dd_subcycle;
	logic sx_rollback_en, dd_rollback_en, dd_sync_store_success;
	scalar_t sx_rollback_pc, dd_rollback_pc, dd_request_addr, cr_read_value;
	logic wb_rollback_en;
	thread_idx_t wb_rollback_thread_idx;
	scalar_t wb_rollback_pc;
	pipeline_sel_t wb_rollback_pipeline;
	subcycle_t wb_rollback_subcycle;
	logic wb_writeback_en, wb_writeback_is_vector, wb_writeback_is_last_subcycle;
	thread_idx_t wb_writeback_thread_idx;
	vector_t wb_writeback_value;
	mask_t wb_writeback_mask;
	register_idx_t wb_writeback_reg;
	thread_idx_t read_thread_idx;
	register_idx_t read_reg_idx;
	logic read_is_vector;
	vector_t read_value;

	row_t table_rows[$];
	logic table_ready = 1'b0;
	int errors = 0;
	logic [15:0] lfsr_state = 16'd93;
	scalar_t scalar_model [`NUM_THREADS][`NUM_REGS];
	vector_t vector_model [`NUM_THREADS][`NUM_REGS];

	writeback_top i_writeback_top(.*);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Taps 16, 14, 13, 11
	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = {lfsr_state[14:0],
				lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
			bits = {bits[30:0], lfsr_state[15]};
		end
		return bits;
	endfunction

	function automatic vector_t random_vector();
		vector_t v;
		for (int i = 0; i < `VECTOR_LANES; i++)
			v[i] = lfsr_bits(32);
		return v;
	endfunction

	// Byte k of a big-endian word, k = 0 is the lowest address
	function automatic logic [7:0] be_byte(input scalar_t word, input int k);
		return word[31 - 8 * k -: 8];
	endfunction

	function automatic scalar_t byte_swap(input scalar_t word);
		return {be_byte(word, 3), be_byte(word, 2), be_byte(word, 1), be_byte(word, 0)};
	endfunction

	function automatic scalar_t expect_aligned(input vector_t line, input scalar_t addr,
		input mem_op_t op);
		scalar_t word;
		logic [7:0] b;
		logic [15:0] h;
		word = line[`VECTOR_LANES - 1 - int'(addr[3:2])];
		b = be_byte(word, int'(addr[1:0]));
		h = {be_byte(word, 2 * int'(addr[1]) + 1), be_byte(word, 2 * int'(addr[1]))};
		case (op)
			MEM_B: return {24'h0, b};
			MEM_BX: return {{24{b[7]}}, b};
			MEM_S: return {16'h0, h};
			MEM_SX: return {{16{h[15]}}, h};
			default: return byte_swap(word);
		endcase
	endfunction

	task automatic add_row(input int pipe, input logic has_dest, input int dest,
		input logic vec, input logic cmp, input logic call, input logic load,
		input mem_op_t op, input int last_sub, input scalar_t addr, input int thread,
		input mask_t mask, input int sub, input logic rb_req, input scalar_t rb_pc,
		input logic exp_rb, input logic exp_wen, input mask_t exp_mask);
		row_t r;
		r.pipe = pipe;
		r.instr = '{has_dest, register_idx_t'(dest), vec, cmp, call, load, op,
			subcycle_t'(last_sub)};
		r.addr = addr;
		r.thread = thread_idx_t'(thread);
		r.mask = mask;
		r.sub = subcycle_t'(sub);
		r.rb_req = rb_req;
		r.rb_pc = rb_pc;
		r.exp_rb = exp_rb;
		r.exp_wen = exp_wen;
		r.exp_mask = exp_mask;
		table_rows.push_back(r);
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		if (got !== expected)
		begin
			$display("error %s: got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic drive_idle();
		mx_valid = 1'b0;
		sx_valid = 1'b0;
		dd_valid = 1'b0;
		sx_rollback_en = 1'b0;
		dd_rollback_en = 1'b0;
	endtask

	task automatic apply_row(input row_t r);
		scalar_t aligned, exp_pc;
		pipeline_sel_t exp_pipe;
		subcycle_t exp_sub;
		vector_t exp_value, model;
		mask_t exp_mask;
		@(negedge clk);
		mx_valid = r.pipe == MX;
		sx_valid = r.pipe == SX;
		dd_valid = r.pipe == DD;
		mx_instruction = r.instr;
		sx_instruction = r.instr;
		dd_instruction = r.instr;
		mx_mask = r.mask;
		sx_mask = r.mask;
		dd_mask = r.mask;
		mx_thread_idx = r.thread;
		sx_thread_idx = r.thread;
		dd_thread_idx = r.thread;
		mx_subcycle = r.sub;
		sx_subcycle = r.sub;
		dd_subcycle = r.sub;
		sx_rollback_en = r.pipe == SX && r.rb_req;
		dd_rollback_en = r.pipe == DD && r.rb_req;
		sx_rollback_pc = r.rb_pc;
		dd_rollback_pc = r.rb_pc;
		dd_request_addr = r.addr;
		dd_read_data = random_vector();
		mx_result = random_vector();
		sx_result = random_vector();
		cr_read_value = lfsr_bits(32);
		dd_sync_store_success = lfsr_bits(1) == 32'd1;
		aligned = expect_aligned(dd_read_data, r.addr, r.instr.mem_op);

		// Rollback priority, PC writes first, then pass-through requests
		exp_pc = r.rb_pc;
		exp_sub = r.sub;
		exp_pipe = r.pipe == DD ? PIPE_MEM : PIPE_SCYCLE_ARITH;
		if (r.pipe == SX && r.instr.has_dest && !r.instr.dest_is_vector
			&& r.instr.dest_reg == `REG_PC)
		begin
			exp_pc = sx_result[0];
			exp_sub = '0;
		end
		else if (r.pipe == DD && r.instr.is_load && r.instr.has_dest
			&& !r.instr.dest_is_vector && r.instr.dest_reg == `REG_PC && !r.rb_req)
		begin
			exp_pc = aligned;
			exp_sub = '0;
		end

		#(PERIOD / 4);
		check_value("wb_rollback_en", wb_rollback_en, r.exp_rb);
		if (r.exp_rb)
		begin
			check_value("wb_rollback_pc", wb_rollback_pc, exp_pc);
			check_value("wb_rollback_thread_idx", wb_rollback_thread_idx, r.thread);
			check_value("wb_rollback_pipeline", wb_rollback_pipeline, exp_pipe);
			check_value("wb_rollback_subcycle", wb_rollback_subcycle, exp_sub);
		end

		exp_value = '0;
		exp_mask = r.mask;
		if (r.pipe != DD)
		begin
			model = r.pipe == MX ? mx_result : sx_result;
			exp_value = model;
			if (r.instr.is_compare)
			begin
				exp_value = '0;
				for (int i = 0; i < `VECTOR_LANES; i++)
					exp_value[0][i] = model[i][0];
			end
		end
		else if (!r.instr.is_load)
		begin
			exp_value[0] = scalar_t'(dd_sync_store_success);
			exp_mask = '1;
		end
		else
		begin
			for (int i = 0; i < `VECTOR_LANES; i++)
			begin
				case (r.instr.mem_op)
					MEM_CONTROL_REG: exp_value[i] = cr_read_value;
					MEM_BLOCK: exp_value[i] = byte_swap(dd_read_data[i]);
					default: exp_value[i] = aligned;
				endcase
			end
			if (r.instr.mem_op == MEM_GATHER)
				exp_mask = r.mask & mask_t'(1 << (`VECTOR_LANES - 1 - int'(r.sub)));
			else if (r.instr.mem_op != MEM_BLOCK)
				exp_mask = '1;
		end

		@(negedge clk);
		drive_idle();
		check_value("wb_writeback_en", wb_writeback_en, r.exp_wen);
		if (r.exp_wen)
		begin
			check_value("wb_writeback_mask", wb_writeback_mask, r.exp_mask);
			check_value("wb_writeback_value", wb_writeback_value, exp_value);
			check_value("wb_writeback_reg", wb_writeback_reg, r.instr.dest_reg);
			check_value("wb_writeback_thread_idx", wb_writeback_thread_idx, r.thread);
			check_value("wb_writeback_is_vector", wb_writeback_is_vector,
				r.instr.dest_is_vector);
			check_value("wb_writeback_is_last_subcycle", wb_writeback_is_last_subcycle,
				r.sub == r.instr.last_subcycle);
			for (int i = 0; i < `VECTOR_LANES; i++)
			begin
				if (r.instr.dest_is_vector && exp_mask[i])
					vector_model[r.thread][r.instr.dest_reg][i] = exp_value[i];
			end
			if (!r.instr.dest_is_vector)
				scalar_model[r.thread][r.instr.dest_reg] = exp_value[0];
		end

		// Register file takes the write on the following edge
		@(negedge clk);

		// Committed state, with untouched lanes still holding old data
		read_thread_idx = r.thread;
		read_reg_idx = r.instr.dest_reg;
		read_is_vector = r.instr.dest_is_vector;
		#(PERIOD / 4);
		model = r.instr.dest_is_vector ? vector_model[r.thread][r.instr.dest_reg]
			: {`VECTOR_LANES{scalar_model[r.thread][r.instr.dest_reg]}};
		check_value("read_value", read_value, model);
	endtask

	initial
	begin
		wait (table_ready);
		#((table_rows.size() * 4 + 20) * PERIOD);
		$display("Watchdog expired before the test sequence finished");
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		drive_idle();
		{mx_instruction, sx_instruction, dd_instruction} = '0;
		{mx_result, sx_result, dd_read_data} = '0;
		{mx_mask, sx_mask, dd_mask} = '0;
		{mx_thread_idx, sx_thread_idx, dd_thread_idx} = '0;
		{mx_subcycle, sx_subcycle, dd_subcycle} = '0;
		{sx_rollback_pc, dd_rollback_pc, dd_request_addr, cr_read_value} = '0;
		dd_sync_store_success = 1'b0;
		read_thread_idx = '0;
		read_reg_idx = '0;
		read_is_vector = 1'b0;
		for (int t = 0; t < `NUM_THREADS; t++)
		begin
			for (int g = 0; g < `NUM_REGS; g++)
			begin
				scalar_model[t][g] = '0;
				vector_model[t][g] = '0;
			end
		end

		// Scalar loads of every width and byte offset
		add_row(DD, 1, 1, 0, 0, 0, 1, MEM_B, 0, 32'h0, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 2, 0, 0, 0, 1, MEM_B, 0, 32'h5, 1, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 3, 0, 0, 0, 1, MEM_B, 0, 32'ha, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 4, 0, 0, 0, 1, MEM_B, 0, 32'hf, 1, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 5, 0, 0, 0, 1, MEM_BX, 0, 32'h0, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 6, 0, 0, 0, 1, MEM_BX, 0, 32'h7, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 7, 0, 0, 0, 1, MEM_BX, 0, 32'h9, 1, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 8, 0, 0, 0, 1, MEM_BX, 0, 32'he, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 9, 0, 0, 0, 1, MEM_S, 0, 32'h2, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 13, 0, 0, 0, 1, MEM_S, 0, 32'h8, 1, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 14, 0, 0, 0, 1, MEM_SX, 0, 32'h6, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 15, 0, 0, 0, 1, MEM_SX, 0, 32'hc, 1, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 16, 0, 0, 0, 1, MEM_L, 0, 32'h4, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		// Block loads, then gathers one lane per subcycle
		add_row(DD, 1, 5, 1, 0, 0, 1, MEM_BLOCK, 0, 32'h0, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 5, 1, 0, 0, 1, MEM_BLOCK, 0, 32'h0, 0, 4'ha, 0, 0, 0, 0, 1, 4'ha);
		add_row(DD, 1, 6, 1, 0, 0, 1, MEM_GATHER, 3, 32'h4, 1, 4'hf, 0, 0, 0, 0, 1, 4'h8);
		add_row(DD, 1, 6, 1, 0, 0, 1, MEM_GATHER, 3, 32'h8, 1, 4'h6, 1, 0, 0, 0, 1, 4'h4);
		add_row(DD, 1, 6, 1, 0, 0, 1, MEM_GATHER, 3, 32'hc, 1, 4'hb, 3, 0, 0, 0, 1, 4'h1);
		// Compares and a plain masked vector result
		add_row(SX, 1, 8, 0, 1, 0, 0, MEM_B, 0, 32'h0, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(MX, 1, 9, 0, 1, 0, 0, MEM_B, 0, 32'h0, 1, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(MX, 1, 12, 1, 0, 0, 0, MEM_B, 0, 32'h0, 0, 4'h3, 0, 0, 0, 0, 1, 4'h3);
		// Rollback priority and the call exception
		add_row(SX, 1, 31, 0, 0, 0, 0, MEM_B, 0, 32'h0, 0, 4'hf, 0, 0, 0, 1, 0, 4'hf);
		add_row(DD, 1, 31, 0, 0, 0, 1, MEM_L, 0, 32'h8, 1, 4'hf, 0, 0, 0, 1, 0, 4'hf);
		add_row(SX, 1, 10, 0, 0, 0, 0, MEM_B, 0, 32'h0, 0, 4'hf, 2, 1, 32'h400, 1, 0, 4'hf);
		add_row(SX, 1, 30, 0, 0, 1, 0, MEM_B, 0, 32'h0, 1, 4'hf, 0, 1, 32'h800, 1, 1, 4'hf);
		add_row(DD, 1, 31, 0, 0, 0, 1, MEM_L, 0, 32'h4, 0, 4'hf, 3, 1, 32'hc00, 1, 0, 4'hf);
		// Sync store success and control-register load
		add_row(DD, 1, 11, 0, 0, 0, 0, MEM_SYNC, 0, 32'h0, 0, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		add_row(DD, 1, 12, 0, 0, 0, 1, MEM_CONTROL_REG, 0, 32'h0, 1, 4'hf, 0, 0, 0, 0, 1, 4'hf);
		table_ready = 1'b1;

		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#(PERIOD / 4);
		check_value("wb_writeback_en", wb_writeback_en, 1'b0);
		check_value("wb_rollback_en", wb_rollback_en, 1'b0);
		check_value("read_value", read_value, '0);
		read_thread_idx = 1'b1;
		read_reg_idx = 5'd31;
		read_is_vector = 1'b1;
		#1;
		check_value("read_value", read_value, '0);

		foreach (table_rows[i])
			apply_row(table_rows[i]);

		@(negedge clk);
		$display("Checks done over %0d rows with %0d errors", table_rows.size(), errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+.
wb_pkg.sv
writeback_if.sv
load_aligner.sv
rollback_arbiter.sv
writeback_stage.sv
vector_register_file.sv
writeback_top.sv
writeback_assertions.sv
writeback_tb.sv

// File: Makefile
# Verilator build and run for the writeback testbench

VERILATOR ?= verilator
TOP ?= writeback_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) wb_settings.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run fails unless the pass line shows up in the output
run: $(BIN)
	@./$(BIN) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)
